// ==== include/flow_params.svh ====
//----------------------------------------
// Flow steering parameters
// Global sizes shared by the packages and
// the stream steering RTL.
//----------------------------------------

`ifndef FLOW_PARAMS_SVH
`define FLOW_PARAMS_SVH

// Number of output flows.
// Select values are always below this count.
`define FLOW_NUM_FLOWS 4

// Width of the data word in each payload.
`define FLOW_DATA_WIDTH 16

// Resulting payload size with the 4-bit tag.
// 4 + 16 = 20 bits on every output stream.
// The ingress request adds the 2-bit select.
// 2 + 20 = 22 bits on the push stream.

`endif

// ==== rtl/flowDataPkg.sv ====
//----------------------------------------
// Flow data types
// Payload carried on the output streams.
//----------------------------------------

`include "flow_params.svh"

package flowDataPkg;

  // One payload item.
  // The tag travels with the data unchanged.
  typedef struct packed {
    logic [3:0]                  tag;
    logic [`FLOW_DATA_WIDTH-1:0] data;
  } flowPayloadT;

  // One payload per output flow.
  // Index i belongs to flow i.
  typedef flowPayloadT [`FLOW_NUM_FLOWS-1:0] flowPayloadVecT;

endpackage

// ==== rtl/flowCtrlPkg.sv ====
//----------------------------------------
// Flow routing types
// Flow number and the ingress request.
//----------------------------------------

`include "flow_params.svh"

package flowCtrlPkg;

  import flowDataPkg::*;

  // Destination flow number.
  typedef logic [$clog2(`FLOW_NUM_FLOWS)-1:0] flowIdT;

  // Ingress item.
  // Sel picks the output, payload is forwarded.
  typedef struct packed {
    flowIdT      sel;
    flowPayloadT payload;
  } flowReqT;

endpackage

// ==== rtl/flowRegFwd.sv ====
//----------------------------------------
// Forward register stage
// One-entry ready-valid register that
// breaks the forward valid and data path.
//----------------------------------------

`timescale 1ns/1ps

module flowRegFwd #(
  // Payload type held by the stage.
  parameter type T = logic
) (
  input  logic clk,
  input  logic arstN,

  // Push side.
  output logic pushReady,
  input  logic pushValid,
  input  T     pushData,

  // Pop side.
  input  logic popReady,
  output logic popValid,
  output T     popData
);

  //----------------------------------------
  // Handshake
  //----------------------------------------

  // Accept when empty or when the held item leaves.
  // Combinational path from popReady to pushReady.
  assign pushReady = !popValid || popReady;

  //----------------------------------------
  // Storage
  //----------------------------------------

  // Valid bit.
  // Loads the push valid on every open slot.
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      popValid <= 1'b0;
    end else if (pushReady) begin
      popValid <= pushValid;
    end
  end

  // Payload.
  // Only captured on a real push handshake.
  always_ff @(posedge clk) begin
    if (pushReady && pushValid) begin
      popData <= pushData;
    end
  end

  // The consumer only sees registered values.
  // Glitches on pushValid or pushData before
  // the edge never reach the pop side.

endmodule

// ==== rtl/flowDemuxSelectUnstable.sv ====
//----------------------------------------
// Combinational flow demux
// Routes one input stream to the flow
// named by an explicit binary select.
//----------------------------------------

`timescale 1ns/1ps

`include "flow_params.svh"

module flowDemuxSelectUnstable
  import flowDataPkg::*, flowCtrlPkg::*;
(
  // Destination of the current item.
  input  flowIdT                       select,

  // Push side.
  output logic                         pushReady,
  input  logic                         pushValid,
  input  flowPayloadT                  pushData,

  // Pop side, one stream per flow.
  input  logic [`FLOW_NUM_FLOWS-1:0]   popReady,
  output logic [`FLOW_NUM_FLOWS-1:0]   popValidUnstable,
  output flowPayloadVecT               popDataUnstable
);

  // One-hot flow enable from the select.
  logic [`FLOW_NUM_FLOWS-1:0] flowEnable;

  //----------------------------------------
  // Select decode
  //----------------------------------------

  always_comb begin
    flowEnable         = '0;
    flowEnable[select] = 1'b1;
  end

  //----------------------------------------
  // Forward path
  //----------------------------------------

  // Valid only on the selected flow.
  // Follows select and pushValid with no delay.
  assign popValidUnstable = flowEnable & {`FLOW_NUM_FLOWS{pushValid}};

  // Payload fans out to every flow.
  // Unselected flows ignore it since their valid is low.
  always_comb begin
    for (int i = 0; i < `FLOW_NUM_FLOWS; i++) begin
      popDataUnstable[i] = pushData;
    end
  end

  //----------------------------------------
  // Backward path
  //----------------------------------------

  // Ready of the selected flow only.
  // A stalled flow blocks the input while it is selected.
  assign pushReady = |(flowEnable & popReady);

endmodule

// ==== rtl/flowDemuxSelect.sv ====
//----------------------------------------
// Flow demux with select
// Combinational demux followed by one
// forward register on every flow.
//----------------------------------------

`timescale 1ns/1ps

`include "flow_params.svh"

module flowDemuxSelect
  import flowDataPkg::*, flowCtrlPkg::*;
(
  input  logic                         clk,
  input  logic                         arstN,

  // Destination of the current item.
  input  flowIdT                       select,

  // Push side.
  output logic                         pushReady,
  input  logic                         pushValid,
  input  flowPayloadT                  pushData,

  // Pop side, one stream per flow.
  input  logic [`FLOW_NUM_FLOWS-1:0]   popReady,
  output logic [`FLOW_NUM_FLOWS-1:0]   popValid,
  output flowPayloadVecT               popData
);

  // Links between the demux and the flow registers.
  logic [`FLOW_NUM_FLOWS-1:0] internalReady;
  logic [`FLOW_NUM_FLOWS-1:0] internalValidUnstable;
  flowPayloadVecT             internalDataUnstable;

  //----------------------------------------
  // Combinational demux
  //----------------------------------------

  flowDemuxSelectUnstable demuxInst (
    .select           (select),
    .pushReady        (pushReady),
    .pushValid        (pushValid),
    .pushData         (pushData),
    .popReady         (internalReady),
    .popValidUnstable (internalValidUnstable),
    .popDataUnstable  (internalDataUnstable)
  );

  //----------------------------------------
  // Per-flow output registers
  //----------------------------------------

  // Each consumer sees stable valid and data.
  // popReady still reaches pushReady combinationally.
  for (genvar i = 0; i < `FLOW_NUM_FLOWS; i++) begin : genPopReg
    flowRegFwd #(
      .T (flowPayloadT)
    ) popRegInst (
      .clk       (clk),
      .arstN     (arstN),
      .pushReady (internalReady[i]),
      .pushValid (internalValidUnstable[i]),
      .pushData  (internalDataUnstable[i]),
      .popReady  (popReady[i]),
      .popValid  (popValid[i]),
      .popData   (popData[i])
    );
  end

endmodule

// ==== rtl/flowSteer.sv ====
//----------------------------------------
// Flow steering top level
// Ingress register, then a demux with
// registered outputs, two cycles deep.
//----------------------------------------

`timescale 1ns/1ps

`include "flow_params.svh"

module flowSteer
  import flowDataPkg::*, flowCtrlPkg::*;
(
  input  logic                         clk,
  input  logic                         arstN,

  // Request stream from the source.
  output logic                         pushReady,
  input  logic                         pushValid,
  input  flowReqT                      pushReq,

  // Output streams, one per flow.
  input  logic [`FLOW_NUM_FLOWS-1:0]   popReady,
  output logic [`FLOW_NUM_FLOWS-1:0]   popValid,
  output flowPayloadVecT               popPayload
);

  // Registered request toward the demux.
  logic    reqValid;
  logic    reqReady;
  flowReqT reqItem;

  // Select split from the held request.
  // Stable while the request is stalled.
  flowIdT  reqSel;

  assign reqSel = reqItem.sel;

  // Ingress stage.
  flowRegFwd #(
    .T (flowReqT)
  ) ingressInst (
    .clk       (clk),
    .arstN     (arstN),
    .pushReady (pushReady),
    .pushValid (pushValid),
    .pushData  (pushReq),
    .popReady  (reqReady),
    .popValid  (reqValid),
    .popData   (reqItem)
  );

  // Steering stage.
  flowDemuxSelect demuxSelectInst (
    .clk       (clk),
    .arstN     (arstN),
    .select    (reqSel),
    .pushReady (reqReady),
    .pushValid (reqValid),
    .pushData  (reqItem.payload),
    .popReady  (popReady),
    .popValid  (popValid),
    .popData   (popPayload)
  );

endmodule

// ==== tb/tbClock.sv ====
//----------------------------------------
// Testbench clock
// Free running clock, low at time zero.
//----------------------------------------

`timescale 1ns/1ps

module tbClock #(
  // Full clock period in ns.
  parameter int periodNs = 20
) (
  output logic clk
);

  // Start low so the first edge is a rising one.
  initial begin
    clk = 1'b0;
  end

  // Toggle every half period.
  always #(periodNs / 2) begin
    clk = ~clk;
  end

endmodule

// ==== tb/flowSteerTb.sv ====
//----------------------------------------
// Flow steering testbench
// Reads request patterns, drives the DUT
// under back-pressure and checks every
// flow against its own scoreboard queue.
//----------------------------------------

`timescale 1ns/1ps

`include "flow_params.svh"

module flowSteerTb
  import flowDataPkg::*, flowCtrlPkg::*;
();

  localparam int numPatterns   = 38;
  localparam int timeoutCycles = 20 * numPatterns + 100;
  localparam int modeOpen      = 0;
  localparam int modeRandom    = 1;
  localparam int modeStall     = 2;
  // Flow held stalled in the last phase.
  localparam flowIdT stallFlow = flowIdT'(1);

  logic                       clk;
  logic                       arstN;
  logic                       pushReady;
  logic                       pushValid;
  flowReqT                    pushReq;
  logic [`FLOW_NUM_FLOWS-1:0] popReady;
  logic [`FLOW_NUM_FLOWS-1:0] popValid;
  flowPayloadVecT             popPayload;

  // Pattern memory and per-flow scoreboards.
  flowReqT     patterns [0:numPatterns-1];
  flowPayloadT expQ [`FLOW_NUM_FLOWS][$];
  int          acceptQ [`FLOW_NUM_FLOWS][$];
  int          expCount [`FLOW_NUM_FLOWS];
  int          poppedCount [`FLOW_NUM_FLOWS];

  // Phase flags from the driver.
  logic openCheck;
  logic latencyCheck;
  logic stallCheck;
  logic runDone;

  // Monitor state.
  logic pushTaken;
  logic sawBlock;
  int   pushCount;
  int   cycleCount;
  int   valueErrors;
  int   otherErrors;

  tbClock #(.periodNs(20)) clockInst (.clk(clk));

  flowSteer flowSteer_inst (
    .clk        (clk),
    .arstN      (arstN),
    .pushReady  (pushReady),
    .pushValid  (pushValid),
    .pushReq    (pushReq),
    .popReady   (popReady),
    .popValid   (popValid),
    .popPayload (popPayload)
  );

  //----------------------------------------
  // Compare tasks
  //----------------------------------------

  task automatic checkPayload(input string name, input flowPayloadT exp, input flowPayloadT act);
    if (exp !== act) begin
      valueErrors++;
      $display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic checkValid(input string name, input logic [`FLOW_NUM_FLOWS-1:0] exp,
                            input logic [`FLOW_NUM_FLOWS-1:0] act);
    if (exp !== act) begin
      valueErrors++;
      $display("Error at %0t: %s expected %b, got %b", $time, name, exp, act);
    end
  endtask

  task automatic checkFlag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      valueErrors++;
      $display("Error at %0t: %s expected %b, got %b", $time, name, exp, act);
    end
  endtask

  task automatic checkCount(input string name, input int exp, input int act);
    if (exp != act) begin
      valueErrors++;
      $display("Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
    end
  endtask

  // Pushed items that no flow has delivered yet.
  function automatic int pending();
    int total;
    total = pushCount;
    for (int f = 0; f < `FLOW_NUM_FLOWS; f++) begin
      total -= poppedCount[f];
    end
    return total;
  endfunction

  //----------------------------------------
  // Driver
  //----------------------------------------

  // Consumer ready for each mode.
  // Random mode stalls about one cycle in four.
  task automatic driveReady(input int mode);
    for (int f = 0; f < `FLOW_NUM_FLOWS; f++) begin
      if (mode == modeRandom) begin
        popReady[f] = ($urandom % 4) != 0;
      end else if (mode == modeStall && f == int'(stallFlow)) begin
        popReady[f] = 1'b0;
      end else begin
        popReady[f] = 1'b1;
      end
    end
  endtask

  // Push patterns first to last.
  // Each is held until the monitor sees it taken.
  // A stall is released once the push side stays blocked for six cycles.
  task automatic sendRange(input int first, input int last, input int mode);
    int idx;
    int curMode;
    int blockedCycles;
    idx           = first;
    curMode       = mode;
    blockedCycles = 0;
    @(negedge clk);
    stallCheck = (mode == modeStall);
    while (idx <= last) begin
      pushValid = 1'b1;
      pushReq   = patterns[idx];
      driveReady(curMode);
      @(negedge clk);
      if (pushTaken) begin
        idx++;
        blockedCycles = 0;
      end else begin
        blockedCycles++;
        if (curMode == modeStall && blockedCycles >= 6) begin
          curMode    = modeOpen;
          stallCheck = 1'b0;
        end
      end
    end
    pushValid  = 1'b0;
    stallCheck = 1'b0;
  endtask

  // Keep popping until every pushed item has come out.
  task automatic drainAll(input int mode);
    while (pending() > 0) begin
      @(negedge clk);
      driveReady(mode);
    end
  endtask

  initial begin
    arstN        = 1'b0;
    pushValid    = 1'b0;
    pushReq      = '0;
    popReady     = '0;
    openCheck    = 1'b0;
    latencyCheck = 1'b0;
    stallCheck   = 1'b0;
    runDone      = 1'b0;
    void'($urandom(60));
    $readmemh("tb/flowSteer_patterns.txt", patterns);
    for (int f = 0; f < `FLOW_NUM_FLOWS; f++) begin
      expCount[f] = 0;
    end
    for (int i = 0; i < numPatterns; i++) begin
      expCount[patterns[i].sel]++;
    end

    // Five reset cycles and two idle cycles.
    repeat (5) @(negedge clk);
    arstN = 1'b1;
    repeat (2) @(negedge clk);

    // Full throughput with fixed two-cycle latency.
    openCheck    = 1'b1;
    latencyCheck = 1'b1;
    sendRange(0, 9, modeOpen);
    drainAll(modeOpen);
    openCheck    = 1'b0;
    latencyCheck = 1'b0;

    // Random back-pressure on every flow.
    sendRange(10, 27, modeRandom);
    drainAll(modeRandom);

    // One flow held until the ingress register blocks.
    sendRange(28, 37, modeStall);
    drainAll(modeOpen);
    runDone = 1'b1;
  end

  //----------------------------------------
  // Monitor and scoreboard
  //----------------------------------------

  // Final counts, queue state and the closing line.
  task automatic reportFinal();
    for (int f = 0; f < `FLOW_NUM_FLOWS; f++) begin
      checkCount($sformatf("poppedCount[%0d]", f), expCount[f], poppedCount[f]);
      checkCount($sformatf("expQ[%0d].size", f), 0, expQ[f].size());
    end
    if (!sawBlock) begin
      otherErrors++;
      $display("Stalled flow %0d never blocked the push side", stallFlow);
    end
    $display("Checks done: %0d value errors, %0d other failures", valueErrors, otherErrors);
  endtask

  initial begin
    pushTaken   = 1'b0;
    sawBlock    = 1'b0;
    pushCount   = 0;
    cycleCount  = 0;
    valueErrors = 0;
    otherErrors = 0;
    for (int f = 0; f < `FLOW_NUM_FLOWS; f++) begin
      poppedCount[f] = 0;
    end
  end

  // Handshakes and checks use the values from before the edge.
  always @(posedge clk) begin
    flowPayloadT expPayload;
    int          acceptCycle;
    cycleCount++;
    if (cycleCount > timeoutCycles) begin
      $display("Timeout after %0d cycles with %0d items still pending", cycleCount, pending());
      $display("TESTBENCH FAILED");
      $finish;
    end else if (runDone) begin
      reportFinal();
      if (valueErrors + otherErrors == 0) begin
        $display("TESTBENCH PASSED");
      end else begin
        $display("TESTBENCH FAILED");
      end
      $finish;
    end else if (arstN) begin
      // Nothing may come out before the first push.
      if (pushCount == 0) begin
        checkValid("popValid", '0, popValid);
      end
      if (openCheck) begin
        checkFlag("pushReady", 1'b1, pushReady);
      end
      // Blocked only with one item held on the flow and one in ingress.
      if (stallCheck) begin
        checkFlag("pushReady", expQ[stallFlow].size() < 2, pushReady);
        if (!pushReady) begin
          sawBlock = 1'b1;
        end
      end

      pushTaken = pushValid && pushReady;
      if (pushTaken) begin
        expQ[pushReq.sel].push_back(pushReq.payload);
        acceptQ[pushReq.sel].push_back(cycleCount);
        pushCount++;
      end

      for (int f = 0; f < `FLOW_NUM_FLOWS; f++) begin
        if (popValid[f] && popReady[f]) begin
          poppedCount[f]++;
          if (expQ[f].size() == 0) begin
            otherErrors++;
            $display("Flow %0d delivered an item at %0t with nothing pending", f, $time);
          end else begin
            expPayload  = expQ[f].pop_front();
            acceptCycle = acceptQ[f].pop_front();
            checkPayload($sformatf("popPayload[%0d]", f), expPayload, popPayload[f]);
            if (latencyCheck) begin
              checkCount($sformatf("latency on flow %0d", f), 2, cycleCount - acceptCycle);
            end
          end
        end
      end
    end
  end

endmodule

// ==== verilog.f ====
+incdir+include
rtl/flowDataPkg.sv
rtl/flowCtrlPkg.sv
rtl/flowRegFwd.sv
rtl/flowDemuxSelectUnstable.sv
rtl/flowDemuxSelect.sv
rtl/flowSteer.sv
tb/tbClock.sv
tb/flowSteerTb.sv

// ==== run.sh ====
#!/bin/sh
# Build the flow steering testbench with Verilator and run it.
# The run passes only when the simulation prints the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module flowSteerTb \
  -Mdir obj_dir -o flowSteerSim || exit 1

simOut=$(./obj_dir/flowSteerSim)
echo "$simOut"
echo "$simOut" | grep -qx "TESTBENCH PASSED" && exit 0 || exit 1

// ==== tb/flowSteer_patterns.txt ====
// One 22-bit request per line: flow (1 digit), tag (1 digit), data (4 digits).
// Lines 0-9 run open, 10-27 under random stalls, 28-37 with flow 1 stalled.
010011
110122
210233
310344
020455
120566
020677
320788
220899
11090A
31A1B2
03C4D5
23E6F7
1409A8
04BBCC
25DDEE
3601F0
0723A4
1845B6
2967C8
3A89DA
0BABEC
1CCDFE
2DEF01
3E1357
0F2468
11369C
227531
13AAAA
040BBB
250CCC
360DDD
070EEE
18F00F
290111
3A0222
1B0333
0C0444
